// File: sim.f
ram_wrap_pkg.sv
addr_split.sv
sram_1r1w_model.sv
word_align_ctrl.sv
rd_resp_fifo.sv
align_shadow_monitor.sv
align_ram_top.sv
tb_align_ram.sv

// File: tb_align_ram.sv
`timescale 1ns/1ps

module tb_align_ram;
  import ram_wrap_pkg::*;

  localparam int clk_period  = 8;
  localparam int num_rand    = 300;
  localparam int plan_ops    = num_addr + 48 + num_rand;
  localparam int cyc_per_op  = 20;
  localparam int drain_limit = 100;
  localparam int watch_adr   = 41;  // lane 2 of row 13.
  localparam int rng_seed    = 32'h4bc9_4dd5;

  logic                  clk;
  logic                  rst;
  logic                  wr_en;
  logic [bit_addr-1:0]   wr_adr;
  logic [word_width-1:0] wr_data;
  logic [word_width-1:0] wr_mask;
  logic                  rd_en;
  logic [bit_addr-1:0]   rd_adr;
  logic                  rd_credit;
  logic [bit_addr-1:0]   mon_adr;
  logic                  rd_vld;
  logic [word_width-1:0] rd_data;
  logic                  rd_req_credit;
  logic                  mon_err;

  logic [word_width-1:0] ref_mem [num_addr];
  logic [word_width-1:0] exp_q [$];
  int req_cred = resp_depth;  // client request credits.
  int held = 0;               // responses sitting in client buffer.
  bit hold_credit = 1'b0;
  bit rand_credit = 1'b0;
  int resp_cnt = 0;
  int errors = 0;
  int checks = 0;
  int cyc = 0;
  int last_rd_cyc = 0;
  int last_vld_cyc = 0;

  align_ram_top i_align_ram_top (
    .clk           (clk),
    .rst           (rst),
    .wr_en         (wr_en),
    .wr_adr        (wr_adr),
    .wr_data       (wr_data),
    .wr_mask       (wr_mask),
    .rd_en         (rd_en),
    .rd_adr        (rd_adr),
    .rd_credit     (rd_credit),
    .mon_adr       (mon_adr),
    .rd_vld        (rd_vld),
    .rd_data       (rd_data),
    .rd_req_credit (rd_req_credit),
    .mon_err       (mon_err)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  // response side, sampled mid-cycle.
  always @(negedge clk) begin
    if (!rst) begin
      compare("rd_req_credit", rd_req_credit, rd_vld);
      compare("mon_err", mon_err, 0);
      if (rd_en) begin
        last_rd_cyc = cyc;
      end
      if (rd_vld) begin
        last_vld_cyc = cyc;
        resp_cnt++;
        held++;
        if (exp_q.size() == 0) begin
          errors++;
          $display("response arrived with no read outstanding");
        end else begin
          compare("rd_data", rd_data, exp_q.pop_front());
        end
        if (held > resp_credits) begin
          errors++;
          $display("client buffer overrun, %0d responses held", held);
        end
      end
      if (rd_req_credit) begin
        req_cred++;
      end
    end
  end

  task automatic drive_cycle(input bit do_wr, input int wa, input logic [word_width-1:0] wd,
                             input logic [word_width-1:0] wm, input bit do_rd, input int ra);
    @(posedge clk);
    wr_en   <= do_wr;
    wr_adr  <= bit_addr'(wa);
    wr_data <= wd;
    wr_mask <= wm;
    rd_en   <= do_rd;
    rd_adr  <= bit_addr'(ra);
    if (do_rd) begin
      if (req_cred <= 0) begin
        errors++;
        $display("read issued without a request credit");
      end
      exp_q.push_back(ref_mem[ra]);  // old word, before a same-cycle write.
      req_cred--;
    end
    if (do_wr) begin
      ref_mem[wa] = (wd & wm) | (ref_mem[wa] & ~wm);
    end
    if (!hold_credit && held > 0 && (!rand_credit || $urandom_range(1, 0) == 1)) begin
      rd_credit <= 1'b1;
      held--;
    end else begin
      rd_credit <= 1'b0;
    end
  endtask

  task automatic idle_cycle();
    drive_cycle(1'b0, 0, '0, '0, 1'b0, 0);
  endtask

  task automatic drain_responses();
    int n;
    n = 0;
    while ((exp_q.size() != 0 || held != 0 || req_cred != resp_depth) && n < drain_limit) begin
      idle_cycle();
      n++;
    end
    if (n >= drain_limit) begin
      errors++;
      $display("responses did not drain within %0d cycles", drain_limit);
    end
  endtask

  task automatic reset_values();
    @(negedge clk);
    compare("rd_vld", rd_vld, 0);
    compare("rd_req_credit", rd_req_credit, 0);
    compare("mon_err", mon_err, 0);
  endtask

  task automatic fill_memory();
    for (int a = 0; a < num_addr; a++) begin
      drive_cycle(1'b1, a, word_width'(a * 16'h0251) ^ 16'hc3a5, '1, 1'b0, 0);
    end
  endtask

  task automatic write_then_read();
    drive_cycle(1'b1, 10, 16'h1234, '1, 1'b0, 0);
    drive_cycle(1'b0, 0, '0, '0, 1'b1, 10);
    drain_responses();
    compare("rd_latency", last_vld_cyc - last_rd_cyc, 4);
  endtask

  task automatic partial_masks();
    int a;
    logic [word_width-1:0] m;
    for (int k = 0; k < 3; k++) begin
      a = $urandom_range(num_addr - 1, 0);
      m = word_width'($urandom);
      drive_cycle(1'b1, a, word_width'($urandom), m, 1'b0, 0);
      drive_cycle(1'b1, a, word_width'($urandom), ~m, 1'b0, 0);
      drive_cycle(1'b0, 0, '0, '0, 1'b1, a);
    end
    drain_responses();
  endtask

  task automatic check_row(input int base);
    for (int i = 0; i < num_wrds; i++) begin
      drive_cycle(1'b1, base + i, word_width'(16'h1111 * (i + 1)) ^ word_width'(base), '1,
                  1'b0, 0);
    end
    drive_cycle(1'b1, base + 1, 16'hbeef, 16'h0ff0, 1'b0, 0);  // middle lane only.
    for (int i = 0; i < num_wrds; i++) begin
      drive_cycle(1'b0, 0, '0, '0, 1'b1, base + i);
    end
    drain_responses();
  endtask

  task automatic lane_isolation();
    check_row(21);
    check_row(num_addr - num_wrds);  // last row.
  endtask

  task automatic back_pressure();
    int start;
    hold_credit = 1'b1;
    start = resp_cnt;
    for (int i = 0; i < resp_depth; i++) begin
      drive_cycle(1'b0, 0, '0, '0, 1'b1, 60 + i);
    end
    compare("req_cred", req_cred, 0);
    repeat (12) idle_cycle();
    compare("resp_under_hold", resp_cnt - start, resp_credits);
    compare("req_cred_under_hold", req_cred, resp_credits);
    @(negedge clk);
    compare("rd_vld", rd_vld, 0);
    hold_credit = 1'b0;
    drain_responses();
    compare("resp_after_release", resp_cnt - start, resp_depth);
  endtask

  function automatic int pick_adr();
    if ($urandom_range(2, 0) == 0) begin
      return watch_adr;
    end
    return $urandom_range(num_addr - 1, 0);
  endfunction

  task automatic random_traffic();
    bit w;
    bit r;
    int wa;
    int ra;
    logic [word_width-1:0] wd;
    logic [word_width-1:0] wm;
    rand_credit = 1'b1;
    repeat (num_rand) begin
      w  = $urandom_range(1, 0);
      r  = (req_cred > 0) && ($urandom_range(1, 0) == 1);
      wa = pick_adr();
      ra = pick_adr();
      wd = word_width'($urandom);
      wm = ($urandom_range(3, 0) == 0) ? '1 : word_width'($urandom);
      drive_cycle(w, wa, wd, wm, r, ra);
    end
    rand_credit = 1'b0;
    drain_responses();
  endtask

  initial begin
    #(plan_ops * cyc_per_op * clk_period);
    $display("watchdog expired before the tests finished");
    $display("TESTS FAILED");
    $finish;
  end

  initial begin
    void'($urandom(rng_seed));
    rst       = 1'b1;
    wr_en     = 1'b0;
    wr_adr    = '0;
    wr_data   = '0;
    wr_mask   = '0;
    rd_en     = 1'b0;
    rd_adr    = '0;
    rd_credit = 1'b0;
    mon_adr   = bit_addr'(watch_adr);
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    reset_values();
    fill_memory();
    write_then_read();
    partial_masks();
    lane_isolation();
    back_pressure();
    random_traffic();
    repeat (4) idle_cycle();
    $display("checks: %0d  errors: %0d  responses: %0d", checks, errors, resp_cnt);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: align_ram_top.sv
`timescale 1ns/1ps

module align_ram_top (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                wr_en,
  input  logic [ram_wrap_pkg::bit_addr-1:0]   wr_adr,
  input  logic [ram_wrap_pkg::word_width-1:0] wr_data,
  input  logic [ram_wrap_pkg::word_width-1:0] wr_mask,
  input  logic                                rd_en,
  input  logic [ram_wrap_pkg::bit_addr-1:0]   rd_adr,
  input  logic                                rd_credit,
  input  logic [ram_wrap_pkg::bit_addr-1:0]   mon_adr,
  output logic                                rd_vld,
  output logic [ram_wrap_pkg::word_width-1:0] rd_data,
  output logic                                rd_req_credit,
  output logic                                mon_err
);
  import ram_wrap_pkg::*;

  logic                  mem_wr_en;
  logic [bit_srow-1:0]   mem_wr_adr;
  row_word_t             mem_wr_data;
  row_word_t             mem_wr_mask;
  logic                  mem_rd_en;
  logic [bit_srow-1:0]   mem_rd_adr;
  row_word_t             mem_rd_data;
  logic                  push;
  logic [word_width-1:0] push_data;

  word_align_ctrl i_word_align_ctrl (
    .clk         (clk),
    .rst         (rst),
    .wr_en       (wr_en),
    .wr_adr      (wr_adr),
    .wr_data     (wr_data),
    .wr_mask     (wr_mask),
    .rd_en       (rd_en),
    .rd_adr      (rd_adr),
    .mem_wr_en   (mem_wr_en),
    .mem_wr_adr  (mem_wr_adr),
    .mem_wr_data (mem_wr_data),
    .mem_wr_mask (mem_wr_mask),
    .mem_rd_en   (mem_rd_en),
    .mem_rd_adr  (mem_rd_adr),
    .mem_rd_data (mem_rd_data),
    .push        (push),
    .push_data   (push_data)
  );

  sram_1r1w_model i_sram_1r1w_model (
    .clk         (clk),
    .mem_wr_en   (mem_wr_en),
    .mem_wr_adr  (mem_wr_adr),
    .mem_wr_data (mem_wr_data),
    .mem_wr_mask (mem_wr_mask),
    .mem_rd_en   (mem_rd_en),
    .mem_rd_adr  (mem_rd_adr),
    .mem_rd_data (mem_rd_data)
  );

  rd_resp_fifo i_rd_resp_fifo (
    .clk           (clk),
    .rst           (rst),
    .push          (push),
    .push_data     (push_data),
    .rd_credit     (rd_credit),
    .rd_vld        (rd_vld),
    .rd_data       (rd_data),
    .rd_req_credit (rd_req_credit)
  );

  align_shadow_monitor i_align_shadow_monitor (
    .clk         (clk),
    .rst         (rst),
    .mon_adr     (mon_adr),
    .wr_en       (wr_en),
    .wr_adr      (wr_adr),
    .wr_data     (wr_data),
    .wr_mask     (wr_mask),
    .mem_wr_en   (mem_wr_en),
    .mem_wr_adr  (mem_wr_adr),
    .mem_wr_data (mem_wr_data),
    .mem_wr_mask (mem_wr_mask),
    .mem_rd_en   (mem_rd_en),
    .mem_rd_adr  (mem_rd_adr),
    .mem_rd_data (mem_rd_data),
    .rd_en       (rd_en),
    .rd_adr      (rd_adr),
    .push        (push),
    .push_data   (push_data),
    .mon_err     (mon_err)
  );

endmodule

// File: align_shadow_monitor.sv
`timescale 1ns/1ps

module align_shadow_monitor (
  input  logic                                clk,
  input  logic                                rst,
  input  logic [ram_wrap_pkg::bit_addr-1:0]   mon_adr,
  input  logic                                wr_en,
  input  logic [ram_wrap_pkg::bit_addr-1:0]   wr_adr,
  input  logic [ram_wrap_pkg::word_width-1:0] wr_data,
  input  logic [ram_wrap_pkg::word_width-1:0] wr_mask,
  input  logic                                mem_wr_en,
  input  logic [ram_wrap_pkg::bit_srow-1:0]   mem_wr_adr,
  input  ram_wrap_pkg::row_word_t             mem_wr_data,
  input  ram_wrap_pkg::row_word_t             mem_wr_mask,
  input  logic                                mem_rd_en,
  input  logic [ram_wrap_pkg::bit_srow-1:0]   mem_rd_adr,
  input  ram_wrap_pkg::row_word_t             mem_rd_data,
  input  logic                                rd_en,
  input  logic [ram_wrap_pkg::bit_addr-1:0]   rd_adr,
  input  logic                                push,
  input  logic [ram_wrap_pkg::word_width-1:0] push_data,
  output logic                                mon_err
);
  import ram_wrap_pkg::*;

  logic [bit_srow-1:0]   sel_srow;
  logic [bit_wrds-1:0]   sel_lane;
  logic [word_width-1:0] phy_known;
  logic [word_width-1:0] phy_word;
  logic [word_width-1:0] log_known;
  logic [word_width-1:0] log_word;
  logic [sram_delay-1:0] pchk_vld;
  logic [word_width-1:0] pchk_known [sram_delay];
  logic [word_width-1:0] pchk_word [sram_delay];
  logic [bit_wrds-1:0]   pchk_lane [sram_delay];
  logic [push_delay-1:0] lchk_vld;
  logic [word_width-1:0] lchk_known [push_delay];
  logic [word_width-1:0] lchk_word [push_delay];
  logic                  phy_bad;
  logic                  log_bad;

  addr_split i_mon_split (
    .adr  (mon_adr),
    .srow (sel_srow),
    .lane (sel_lane)
  );

  // shadows start with no known bits.
  always_ff @(posedge clk) begin
    if (rst) begin
      phy_known <= '0;
      log_known <= '0;
    end else begin
      if (mem_wr_en && (mem_wr_adr == sel_srow)) begin
        phy_known <= phy_known | mem_wr_mask.lane[sel_lane];
      end
      if (wr_en && (wr_adr == mon_adr)) begin
        log_known <= log_known | wr_mask;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (mem_wr_en && (mem_wr_adr == sel_srow)) begin
      phy_word <= (mem_wr_data.lane[sel_lane] & mem_wr_mask.lane[sel_lane]) |
                  (phy_word & ~mem_wr_mask.lane[sel_lane]);
    end
    if (wr_en && (wr_adr == mon_adr)) begin
      log_word <= (wr_data & wr_mask) | (log_word & ~wr_mask);
    end
  end

  // snapshot taken at read issue, before any same-cycle write.
  always_ff @(posedge clk) begin
    if (rst) begin
      pchk_vld <= '0;
      lchk_vld <= '0;
    end else begin
      pchk_vld <= {pchk_vld[sram_delay-2:0], mem_rd_en && (mem_rd_adr == sel_srow)};
      lchk_vld <= {lchk_vld[push_delay-2:0], rd_en && (rd_adr == mon_adr)};
    end
  end

  always_ff @(posedge clk) begin
    pchk_known[0] <= phy_known;
    pchk_word[0]  <= phy_word;
    pchk_lane[0]  <= sel_lane;
    for (int i = 1; i < sram_delay; i++) begin
      pchk_known[i] <= pchk_known[i-1];
      pchk_word[i]  <= pchk_word[i-1];
      pchk_lane[i]  <= pchk_lane[i-1];
    end
    lchk_known[0] <= log_known;
    lchk_word[0]  <= log_word;
    for (int i = 1; i < push_delay; i++) begin
      lchk_known[i] <= lchk_known[i-1];
      lchk_word[i]  <= lchk_word[i-1];
    end
  end

  assign phy_bad = pchk_vld[sram_delay-1] &&
                   (((mem_rd_data.lane[pchk_lane[sram_delay-1]] ^ pchk_word[sram_delay-1]) &
                     pchk_known[sram_delay-1]) != '0);

  // a missing push is a mismatch as well.
  assign log_bad = lchk_vld[push_delay-1] &&
                   (!push || (((push_data ^ lchk_word[push_delay-1]) &
                               lchk_known[push_delay-1]) != '0));

  always_ff @(posedge clk) begin
    if (rst) begin
      mon_err <= 1'b0;
    end else if (phy_bad || log_bad) begin
      mon_err <= 1'b1; // sticky.
    end
  end

endmodule

// File: rd_resp_fifo.sv
`timescale 1ns/1ps

module rd_resp_fifo (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                push,
  input  logic [ram_wrap_pkg::word_width-1:0] push_data,
  input  logic                                rd_credit,
  output logic                                rd_vld,
  output logic [ram_wrap_pkg::word_width-1:0] rd_data,
  output logic                                rd_req_credit
);
  import ram_wrap_pkg::*;

  logic [word_width-1:0] resp_mem [resp_depth];
  logic [bit_resp-1:0]   wr_ptr;
  logic [bit_resp-1:0]   rd_ptr;
  logic [bit_resp:0]     fill;
  logic [bit_resp:0]     credits; // response credits held.
  logic                  pop;

  function automatic logic [bit_resp-1:0] ptr_next(input logic [bit_resp-1:0] ptr);
    if (ptr == bit_resp'(resp_depth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign pop = (fill != '0) && (credits != '0);

  // each response frees one request slot for the client.
  assign rd_vld        = pop;
  assign rd_req_credit = pop;
  assign rd_data       = resp_mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) begin
      resp_mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      fill   <= '0;
    end else begin
      if (push) begin
        wr_ptr <= ptr_next(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_next(rd_ptr);
      end
      case ({push, pop})
        2'b10:   fill <= fill + 1'b1;
        2'b01:   fill <= fill - 1'b1;
        default: fill <= fill;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      credits <= (bit_resp + 1)'(resp_credits);
    end else begin
      case ({pop, rd_credit})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
    end
  end

endmodule

// File: word_align_ctrl.sv
`timescale 1ns/1ps

module word_align_ctrl (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                wr_en,
  input  logic [ram_wrap_pkg::bit_addr-1:0]   wr_adr,
  input  logic [ram_wrap_pkg::word_width-1:0] wr_data,
  input  logic [ram_wrap_pkg::word_width-1:0] wr_mask,
  input  logic                                rd_en,
  input  logic [ram_wrap_pkg::bit_addr-1:0]   rd_adr,
  output logic                                mem_wr_en,
  output logic [ram_wrap_pkg::bit_srow-1:0]   mem_wr_adr,
  output ram_wrap_pkg::row_word_t             mem_wr_data,
  output ram_wrap_pkg::row_word_t             mem_wr_mask,
  output logic                                mem_rd_en,
  output logic [ram_wrap_pkg::bit_srow-1:0]   mem_rd_adr,
  input  ram_wrap_pkg::row_word_t             mem_rd_data,
  output logic                                push,
  output logic [ram_wrap_pkg::word_width-1:0] push_data
);
  import ram_wrap_pkg::*;

  logic [bit_srow-1:0]   wr_srow;
  logic [bit_wrds-1:0]   wr_lane;
  logic [bit_srow-1:0]   rd_srow;
  logic [bit_wrds-1:0]   rd_lane;
  logic [push_delay-1:0] vld_pipe;
  logic [bit_wrds-1:0]   lane_pipe [sram_delay];

  addr_split i_wr_split (
    .adr  (wr_adr),
    .srow (wr_srow),
    .lane (wr_lane)
  );

  addr_split i_rd_split (
    .adr  (rd_adr),
    .srow (rd_srow),
    .lane (rd_lane)
  );

  // writes go straight to the row, other lanes masked off.
  assign mem_wr_en  = wr_en;
  assign mem_wr_adr = wr_srow;

  always_comb begin
    mem_wr_data               = '0;
    mem_wr_mask               = '0;
    mem_wr_data.lane[wr_lane] = wr_data;
    mem_wr_mask.lane[wr_lane] = wr_mask;
  end

  assign mem_rd_en  = rd_en;
  assign mem_rd_adr = rd_srow;

  always_ff @(posedge clk) begin
    if (rst) begin
      vld_pipe <= '0;
    end else begin
      vld_pipe <= {vld_pipe[push_delay-2:0], rd_en};
    end
  end

  always_ff @(posedge clk) begin
    lane_pipe[0] <= rd_lane;
    for (int i = 1; i < sram_delay; i++) begin
      lane_pipe[i] <= lane_pipe[i-1];
    end
  end

  // row data lines up with the last lane stage.
  always_ff @(posedge clk) begin
    if (vld_pipe[sram_delay-1]) begin
      push_data <= mem_rd_data.lane[lane_pipe[sram_delay-1]];
    end
  end

  assign push = vld_pipe[push_delay-1];

endmodule

// File: sram_1r1w_model.sv
`timescale 1ns/1ps

module sram_1r1w_model (
  input  logic                              clk,
  input  logic                              mem_wr_en,
  input  logic [ram_wrap_pkg::bit_srow-1:0] mem_wr_adr,
  input  ram_wrap_pkg::row_word_t           mem_wr_data,
  input  ram_wrap_pkg::row_word_t           mem_wr_mask,
  input  logic                              mem_rd_en,
  input  logic [ram_wrap_pkg::bit_srow-1:0] mem_rd_adr,
  output ram_wrap_pkg::row_word_t           mem_rd_data
);
  import ram_wrap_pkg::*;

  row_word_t mem_array [num_srow];
  row_word_t rd_pipe [sram_delay];

  // bit-masked merge into the addressed row.
  always_ff @(posedge clk) begin
    if (mem_wr_en) begin
      mem_array[mem_wr_adr].flat <= (mem_wr_mask.flat & mem_wr_data.flat) |
                                    (~mem_wr_mask.flat & mem_array[mem_wr_adr].flat);
    end
  end

  // read sees the row before a same-cycle write.
  always_ff @(posedge clk) begin
    if (mem_rd_en) begin
      rd_pipe[0] <= mem_array[mem_rd_adr];
    end
    for (int i = 1; i < sram_delay; i++) begin
      rd_pipe[i] <= rd_pipe[i-1];
    end
  end

  assign mem_rd_data = rd_pipe[sram_delay-1];

endmodule

// File: addr_split.sv
`timescale 1ns/1ps

module addr_split (
  input  logic [ram_wrap_pkg::bit_addr-1:0] adr,
  output logic [ram_wrap_pkg::bit_srow-1:0] srow,
  output logic [ram_wrap_pkg::bit_wrds-1:0] lane
);
  import ram_wrap_pkg::*;

  logic [bit_addr-1:0] quo;
  logic [bit_addr-1:0] rem;

  // word count per row need not be a power of two.
  assign quo = adr / bit_addr'(num_wrds);
  assign rem = adr % bit_addr'(num_wrds);

  assign srow = quo[bit_srow-1:0];
  assign lane = rem[bit_wrds-1:0];

endmodule

// File: ram_wrap_pkg.sv
package ram_wrap_pkg;

  // logical memory.
  localparam int word_width = 16;
  localparam int num_addr   = 96;
  localparam int bit_addr   = $clog2(num_addr);

  // physical geometry, three words per row.
  localparam int num_wrds   = 3;
  localparam int bit_wrds   = $clog2(num_wrds);
  localparam int num_srow   = num_addr / num_wrds;
  localparam int bit_srow   = $clog2(num_srow);
  localparam int row_width  = num_wrds * word_width;

  localparam int sram_delay = 2;              // row read to data.
  localparam int push_delay = sram_delay + 1; // row read to fifo push.

  // response path.
  localparam int resp_depth   = 4;
  localparam int bit_resp     = $clog2(resp_depth);
  localparam int resp_credits = 2;

  // one physical row, seen flat or as word lanes.
  typedef union packed {
    logic [row_width-1:0]                flat;
    logic [num_wrds-1:0][word_width-1:0] lane;
  } row_word_t;

endpackage
